/* rtl/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath width of registers, operands and addresses
`define DATA_WIDTH 32

// Architectural integer registers, x0 included
`define REG_COUNT 32

// PC left in the ID/EX register after reset
`define RESET_PC 32'h0000_0000

`endif

/* rtl/CorePkg.sv */
package CorePkg;

`include "core_params.svh"

    typedef logic [`DATA_WIDTH-1:0]         Data;      // Register or operand word
    typedef logic [`DATA_WIDTH-1:0]         InstAddr;  // Instruction address
    typedef logic [$clog2(`REG_COUNT)-1:0]  RegAddr;   // Register index

    // Low three bits follow funct3, bit 3 is funct7[5] for SUB and SRA
    typedef enum logic [3:0] {
        AluAdd   = 4'b0000,
        AluSll   = 4'b0001,
        AluSlt   = 4'b0010,
        AluSltu  = 4'b0011,
        AluXor   = 4'b0100,
        AluSrl   = 4'b0101,
        AluOr    = 4'b0110,
        AluAnd   = 4'b0111,
        AluSub   = 4'b1000,
        AluSra   = 4'b1101,
        AluPassB = 4'b1111   // LUI, immediate passes through
    } AluOp;

    // Conditional branches are {1, funct3}, jumps sit below them
    typedef enum logic [3:0] {
        BrNone = 4'b0000,
        BrJal  = 4'b0001,
        BrJalr = 4'b0010,
        BrEq   = 4'b1000,
        BrNe   = 4'b1001,
        BrLt   = 4'b1100,
        BrGe   = 4'b1101,
        BrLtu  = 4'b1110,
        BrGeu  = 4'b1111
    } BranchOp;

    typedef enum logic [1:0] {
        OpASelReg  = 2'b00,   // rs1 value
        OpASelPc   = 2'b01,   // Instruction PC
        OpASelZero = 2'b10    // Constant zero
    } OperandASel;

    typedef enum logic {
        OpBSelReg = 1'b0,     // rs2 value
        OpBSelImm = 1'b1      // Sign-extended immediate
    } OperandBSel;

    typedef struct packed {
        logic       isValid;      // Stage holds a live instruction
        InstAddr    pc;
        Data        imm;
        Data        dataA;        // rs1 as read in decode
        Data        dataB;        // rs2 as read in decode
        RegAddr     rs1;          // Kept for forwarding compare
        RegAddr     rs2;
        RegAddr     regWrAddr;
        logic       regWrEnable;  // Never set for rd = x0
        OperandASel operandASel;
        OperandBSel operandBSel;
        AluOp       aluControl;
        BranchOp    branchOp;
    } IdExBundle;

    typedef struct packed {
        logic   isValid;
        logic   regWrEnable;
        RegAddr regWrAddr;
        Data    regWrData;        // ALU result or link address
    } ExWbBundle;

endpackage

/* rtl/WritebackIf.sv */
`timescale 1ns/100ps

interface WritebackIf
    import CorePkg::*;
();

    logic   wrValid;   // Write strobe, already held off under stall
    RegAddr wrAddr;    // Destination register
    Data    wrData;    // Value to store

    // EX/WB side drives, register file consumes
    modport source (output wrValid, output wrAddr, output wrData);
    modport sink   (input  wrValid, input  wrAddr, input  wrData);

endinterface

/* rtl/InstDecoder.sv */
`timescale 1ns/100ps

module InstDecoder
    import CorePkg::*;
(
    input  Data        i_inst,         // Instruction word
    output logic       o_isValid,      // Supported and well formed
    output RegAddr     o_rs1,
    output RegAddr     o_rs2,
    output RegAddr     o_regWrAddr,    // rd field
    output logic       o_regWrEnable,  // Writes a register other than x0
    output Data        o_imm,          // Sign-extended immediate
    output OperandASel o_operandASel,
    output OperandBSel o_operandBSel,
    output AluOp       o_aluControl,
    output BranchOp    o_branchOp);

    localparam logic [6:0] OpcOp     = 7'b0110011;
    localparam logic [6:0] OpcOpImm  = 7'b0010011;
    localparam logic [6:0] OpcLui    = 7'b0110111;
    localparam logic [6:0] OpcAuipc  = 7'b0010111;
    localparam logic [6:0] OpcJal    = 7'b1101111;
    localparam logic [6:0] OpcJalr   = 7'b1100111;
    localparam logic [6:0] OpcBranch = 7'b1100011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    Data        immI, immU, immB, immJ;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    assign o_rs1       = i_inst[19:15];
    assign o_rs2       = i_inst[24:20];
    assign o_regWrAddr = i_inst[11:7];

    assign immI = {{20{i_inst[31]}}, i_inst[31:20]};
    assign immU = {i_inst[31:12], 12'b0};
    assign immB = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign immJ = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    always_comb
    begin
        logic writesRd;

        o_isValid     = 1'b1;          // Cleared below on any unsupported encoding
        writesRd      = 1'b1;
        o_imm         = immI;
        o_operandASel = OpASelReg;
        o_operandBSel = OpBSelImm;
        o_aluControl  = AluAdd;
        o_branchOp    = BrNone;

        case (opcode)
            OpcOp:
            begin
                o_operandBSel = OpBSelReg;
                o_aluControl  = AluOp'({funct7[5], funct3});
                // Only SUB and SRA may carry funct7 = 0100000
                if (funct7 != 7'b0000000 &&
                    !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))
                    o_isValid = 1'b0;
            end

            OpcOpImm:
            begin
                o_aluControl = AluOp'({funct3 == 3'b101 && funct7[5], funct3});
                if (funct3 == 3'b001 && funct7 != 7'b0000000)
                    o_isValid = 1'b0;  // SLLI with bad upper bits
                if (funct3 == 3'b101 && funct7 != 7'b0000000 && funct7 != 7'b0100000)
                    o_isValid = 1'b0;  // SRLI or SRAI with bad upper bits
            end

            OpcLui:
            begin
                o_imm         = immU;
                o_operandASel = OpASelZero;
                o_aluControl  = AluPassB;
            end

            OpcAuipc:
            begin
                o_imm         = immU;
                o_operandASel = OpASelPc;  // PC + upper immediate
            end

            OpcJal:
            begin
                o_imm         = immJ;
                o_operandASel = OpASelPc;  // ALU forms the target
                o_branchOp    = BrJal;
            end

            OpcJalr:
            begin
                o_branchOp = BrJalr;       // rs1 + imm, bit 0 cleared in EX
                if (funct3 != 3'b000)
                    o_isValid = 1'b0;
            end

            OpcBranch:
            begin
                o_imm         = immB;
                o_operandASel = OpASelPc;  // Target from ALU, compare on raw registers
                o_branchOp    = BranchOp'({1'b1, funct3});
                writesRd      = 1'b0;
                if (funct3[2:1] == 2'b01)
                    o_isValid = 1'b0;      // funct3 010 and 011 are reserved
            end

            default:
                o_isValid = 1'b0;
        endcase

        o_regWrEnable = writesRd && o_isValid && (o_regWrAddr != '0);
    end

    // A bubble must never carry a register write downstream
    always_comb
    begin
        assert final (o_isValid || !o_regWrEnable)
            else $error("Write enable on an invalid instruction %h", i_inst);
    end

endmodule

/* rtl/RegisterFile.sv */
`timescale 1ns/100ps

`include "core_params.svh"

module RegisterFile
    import CorePkg::*;
(
    input  logic        i_clock,
    input  logic        i_arstN,
    input  RegAddr      i_rdAddrA,   // rs1 read address
    input  RegAddr      i_rdAddrB,   // rs2 read address
    output Data         o_rdDataA,
    output Data         o_rdDataB,
    WritebackIf.sink    wb);         // Write port from EX/WB

    Data regs [1:`REG_COUNT-1];      // x0 has no storage

    always_ff @(posedge i_clock or negedge i_arstN)
    begin
        if (!i_arstN)
        begin
            for (int i = 1; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (wb.wrValid && wb.wrAddr != '0)
            regs[wb.wrAddr] <= wb.wrData;
    end

    // x0 reads zero, a write in flight to the same register is bypassed
    assign o_rdDataA = (i_rdAddrA == '0)                        ? '0 :
                       (wb.wrValid && wb.wrAddr == i_rdAddrA)   ? wb.wrData :
                                                                  regs[i_rdAddrA];
    assign o_rdDataB = (i_rdAddrB == '0)                        ? '0 :
                       (wb.wrValid && wb.wrAddr == i_rdAddrB)   ? wb.wrData :
                                                                  regs[i_rdAddrB];

    // Zero register stays zero even with a write to x0 on the port
    assert property (@(posedge i_clock) disable iff (!i_arstN)
        (i_rdAddrA == '0 |-> o_rdDataA == '0) and (i_rdAddrB == '0 |-> o_rdDataB == '0))
        else $error("Nonzero read of x0");

endmodule

/* rtl/PipelineStage.sv */
`timescale 1ns/100ps

module PipelineStage #(
    parameter type    Payload    = logic,        // Stage bundle, needs an isValid field
    parameter Payload ResetValue = Payload'('0)  // Contents after reset, valid low
) (
    input  logic   i_clock,
    input  logic   i_arstN,
    input  logic   i_stall,    // Hold contents, wins over flush
    input  logic   i_flush,    // Turn the stage into a bubble
    input  Payload i_data,
    output Payload o_data);

    always_ff @(posedge i_clock or negedge i_arstN)
    begin
        if (!i_arstN)
            o_data <= ResetValue;
        else if (!i_stall)
        begin
            if (i_flush)
                o_data.isValid <= 1'b0;  // Payload left as is, only marked dead
            else
                o_data <= i_data;
        end
    end

    // A flush that is not blocked by a stall leaves a bubble
    assert property (@(posedge i_clock) disable iff (!i_arstN)
        (i_flush && !i_stall) |=> !o_data.isValid)
        else $error("Stage still valid after flush");

endmodule

/* rtl/ExecuteUnit.sv */
`timescale 1ns/100ps

module ExecuteUnit
    import CorePkg::*;
(
    input  IdExBundle i_idEx,           // Instruction in execution
    input  ExWbBundle i_exWb,           // One older result, not yet written
    output ExWbBundle o_exWb,           // Result toward writeback
    output logic      o_redirectValid,  // Taken branch or jump
    output InstAddr   o_redirectPc);

    Data     regA, regB;                // Register operands after forwarding
    Data     opA, opB;                  // ALU inputs
    Data     aluResult;
    logic    taken;
    logic    isJump;
    InstAddr linkPc;

    // Forward from EX/WB when it writes a register this instruction reads
    always_comb
    begin
        regA = i_idEx.dataA;
        regB = i_idEx.dataB;
        if (i_exWb.isValid && i_exWb.regWrEnable && i_exWb.regWrAddr != '0)
        begin
            if (i_exWb.regWrAddr == i_idEx.rs1)
                regA = i_exWb.regWrData;
            if (i_exWb.regWrAddr == i_idEx.rs2)
                regB = i_exWb.regWrData;
        end
    end

    always_comb
    begin
        case (i_idEx.operandASel)
            OpASelPc:   opA = i_idEx.pc;
            OpASelZero: opA = '0;
            default:    opA = regA;
        endcase
        opB = (i_idEx.operandBSel == OpBSelImm) ? i_idEx.imm : regB;
    end

    always_comb
    begin
        case (i_idEx.aluControl)
            AluSub:   aluResult = opA - opB;
            AluSll:   aluResult = opA << opB[4:0];
            AluSlt:   aluResult = Data'($signed(opA) < $signed(opB));
            AluSltu:  aluResult = Data'(opA < opB);
            AluXor:   aluResult = opA ^ opB;
            AluSrl:   aluResult = opA >> opB[4:0];
            AluSra:   aluResult = Data'($signed(opA) >>> opB[4:0]);
            AluOr:    aluResult = opA | opB;
            AluAnd:   aluResult = opA & opB;
            AluPassB: aluResult = opB;
            default:  aluResult = opA + opB;  // ADD, AUIPC and all targets
        endcase
    end

    // Compare on register values, ALU is busy forming the target
    always_comb
    begin
        case (i_idEx.branchOp)
            BrJal, BrJalr: taken = 1'b1;
            BrEq:          taken = (regA == regB);
            BrNe:          taken = (regA != regB);
            BrLt:          taken = ($signed(regA) < $signed(regB));
            BrGe:          taken = ($signed(regA) >= $signed(regB));
            BrLtu:         taken = (regA < regB);
            BrGeu:         taken = (regA >= regB);
            default:       taken = 1'b0;
        endcase
    end

    assign isJump = (i_idEx.branchOp == BrJal) || (i_idEx.branchOp == BrJalr);
    assign linkPc = i_idEx.pc + InstAddr'(4);

    assign o_redirectValid = i_idEx.isValid && taken;
    assign o_redirectPc    = {aluResult[$bits(Data)-1:1], 1'b0};  // Bit 0 cleared for JALR

    assign o_exWb.isValid     = i_idEx.isValid;
    assign o_exWb.regWrEnable = i_idEx.regWrEnable;
    assign o_exWb.regWrAddr   = i_idEx.regWrAddr;
    assign o_exWb.regWrData   = isJump ? linkPc : aluResult;

endmodule

/* rtl/IntegerCore.sv */
`timescale 1ns/100ps

`include "core_params.svh"

module IntegerCore
    import CorePkg::*;
(
    input  logic    i_clock,
    input  logic    i_arstN,
    input  logic    i_instValid,      // Instruction offered this cycle
    input  Data     i_inst,
    input  InstAddr i_pc,
    input  logic    i_stall,          // Freezes both stages and the write port
    input  logic    i_flush,          // Empties both stages
    output logic    o_wbValid,        // Retiring instruction writes a register
    output RegAddr  o_wbAddr,
    output Data     o_wbData,
    output logic    o_redirectValid,  // Taken branch or jump in EX
    output InstAddr o_redirectPc);

    // ID/EX starts at the reset PC with harmless controls
    localparam IdExBundle IdExReset = '{
        pc:          `RESET_PC,
        operandASel: OpASelReg,
        operandBSel: OpBSelReg,
        aluControl:  AluAdd,
        branchOp:    BrNone,
        default:     '0
    };

    IdExBundle idExIn, idExQ;         // Decode side and EX side of ID/EX
    ExWbBundle exWbIn, exWbQ;         // EX side and WB side of EX/WB
    logic      decValid;

    WritebackIf wbBus ();

    InstDecoder decoder (
        .i_inst        (i_inst),
        .o_isValid     (decValid),
        .o_rs1         (idExIn.rs1),
        .o_rs2         (idExIn.rs2),
        .o_regWrAddr   (idExIn.regWrAddr),
        .o_regWrEnable (idExIn.regWrEnable),
        .o_imm         (idExIn.imm),
        .o_operandASel (idExIn.operandASel),
        .o_operandBSel (idExIn.operandBSel),
        .o_aluControl  (idExIn.aluControl),
        .o_branchOp    (idExIn.branchOp));

    assign idExIn.isValid = decValid && i_instValid;  // Illegal words enter as bubbles
    assign idExIn.pc      = i_pc;

    RegisterFile regFile (
        .i_clock   (i_clock),
        .i_arstN   (i_arstN),
        .i_rdAddrA (idExIn.rs1),
        .i_rdAddrB (idExIn.rs2),
        .o_rdDataA (idExIn.dataA),
        .o_rdDataB (idExIn.dataB),
        .wb        (wbBus.sink));

    // A redirect squashes the instruction offered alongside it
    PipelineStage #(.Payload(IdExBundle), .ResetValue(IdExReset)) idEx (
        .i_clock (i_clock),
        .i_arstN (i_arstN),
        .i_stall (i_stall),
        .i_flush (i_flush || o_redirectValid),
        .i_data  (idExIn),
        .o_data  (idExQ));

    ExecuteUnit execute (
        .i_idEx          (idExQ),
        .i_exWb          (exWbQ),
        .o_exWb          (exWbIn),
        .o_redirectValid (o_redirectValid),
        .o_redirectPc    (o_redirectPc));

    PipelineStage #(.Payload(ExWbBundle)) exWb (
        .i_clock (i_clock),
        .i_arstN (i_arstN),
        .i_stall (i_stall),
        .i_flush (i_flush),
        .i_data  (exWbIn),
        .o_data  (exWbQ));

    assign o_wbValid = exWbQ.isValid && exWbQ.regWrEnable;
    assign o_wbAddr  = exWbQ.regWrAddr;
    assign o_wbData  = exWbQ.regWrData;

    assign wbBus.wrValid = o_wbValid && !i_stall;     // No write while frozen
    assign wbBus.wrAddr  = exWbQ.regWrAddr;
    assign wbBus.wrData  = exWbQ.regWrData;

endmodule

/* tb/CoreChecker.sv */
`timescale 1ns/100ps

module CoreChecker
    import CorePkg::*;
(
    input  logic    i_clock,
    input  logic    i_arstN,
    input  logic    i_instValid,      // DUT inputs as driven
    input  Data     i_inst,
    input  InstAddr i_pc,
    input  logic    i_stall,
    input  logic    i_flush,
    input  logic    i_wbValid,        // DUT outputs
    input  RegAddr  i_wbAddr,
    input  Data     i_wbData,
    input  logic    i_redirectValid,
    input  InstAddr i_redirectPc,
    output int      o_errorCount,
    output int      o_checkCount,
    output int      o_pending);       // Instructions still owed by the DUT

    typedef struct packed {
        logic    legal;
        logic    writes;              // Writes a register other than x0
        RegAddr  rd;
        Data     value;
        logic    taken;               // Taken branch or any jump
        InstAddr target;
    } ExecResult;

    typedef struct packed {
        RegAddr addr;
        Data    data;
    } WbEntry;

    Data     archRegs [0:31];         // Architectural state in program order
    WbEntry  wbQueue [$];             // Expected retiring writes
    logic    idValid;                 // Model of the instruction waiting in EX
    Data     idInst;
    InstAddr idPc;
    int      errorCount = 0;
    int      checkCount = 0;
    int      pending = 0;

    assign o_errorCount = errorCount;
    assign o_checkCount = checkCount;
    assign o_pending    = pending;

    function automatic Data aluModel(logic [2:0] f3, logic alt, Data a, Data b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101:
            begin
                if (alt)
                    return Data'($signed(a) >>> b[4:0]);  // Sign fills from the left
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // RV32I semantics for the supported groups, operands from the model registers
    function automatic ExecResult runInstruction(Data inst, InstAddr pc);
        ExecResult  r;
        logic [2:0] f3;
        logic [6:0] f7;
        Data        a, b, immI, immU, immB, immJ;

        f3       = inst[14:12];
        f7       = inst[31:25];
        a        = archRegs[inst[19:15]];
        b        = archRegs[inst[24:20]];
        immI     = {{20{inst[31]}}, inst[31:20]};
        immU     = {inst[31:12], 12'h000};
        immB     = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        immJ     = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        r        = '0;
        r.legal  = 1'b1;
        r.writes = 1'b1;
        r.rd     = inst[11:7];
        case (inst[6:0])
            7'b0110011:
            begin
                r.legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
                r.value = aluModel(f3, f7[5], a, b);
            end
            7'b0010011:
            begin
                if (f3 == 3'b001)
                    r.legal = (f7 == 7'h00);                    // SLLI
                if (f3 == 3'b101)
                    r.legal = (f7 == 7'h00) || (f7 == 7'h20);   // SRLI, SRAI
                r.value = aluModel(f3, f3 == 3'b101 && f7[5], a, immI);
            end
            7'b0110111: r.value = immU;                        // LUI
            7'b0010111: r.value = pc + immU;                   // AUIPC
            7'b1101111:
            begin
                r.value  = pc + 32'd4;
                r.taken  = 1'b1;
                r.target = pc + immJ;
            end
            7'b1100111:
            begin
                r.legal  = (f3 == 3'b000);
                r.value  = pc + 32'd4;
                r.taken  = 1'b1;
                r.target = (a + immI) & ~32'd1;                 // Low bit dropped
            end
            7'b1100011:
            begin
                r.writes = 1'b0;
                r.target = pc + immB;
                case (f3)
                    3'b000: r.taken = (a == b);
                    3'b001: r.taken = (a != b);
                    3'b100: r.taken = ($signed(a) < $signed(b));
                    3'b101: r.taken = ($signed(a) >= $signed(b));
                    3'b110: r.taken = (a < b);
                    3'b111: r.taken = (a >= b);
                    default: r.legal = 1'b0;                    // Reserved funct3
                endcase
            end
            default: r.legal = 1'b0;
        endcase
        r.writes = r.writes && r.legal && (r.rd != 5'd0);
        r.taken  = r.taken && r.legal;
        return r;
    endfunction

    task automatic compareValue(string name, Data expected, Data actual);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("[ERROR] %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    always @(posedge i_clock)
    begin
        ExecResult ex;
        ExecResult offered;
        WbEntry    entry;
        logic      expRedirect;

        if (!i_arstN)
        begin
            for (int i = 0; i < 32; i++)
                archRegs[i] = '0;
            wbQueue.delete();
            idValid = 1'b0;
            idInst  = '0;
            idPc    = '0;
        end
        else
        begin
            ex          = runInstruction(idInst, idPc);
            expRedirect = idValid && ex.taken;
            compareValue("o_redirectValid", Data'(expRedirect), Data'(i_redirectValid));
            if (expRedirect)
                compareValue("o_redirectPc", ex.target, i_redirectPc);
            // Head entry stays on the outputs through a stall
            if (wbQueue.size() > 0)
            begin
                compareValue("o_wbValid", 32'd1, Data'(i_wbValid));
                compareValue("o_wbAddr", Data'(wbQueue[0].addr), Data'(i_wbAddr));
                compareValue("o_wbData", wbQueue[0].data, i_wbData);
            end
            else
                compareValue("o_wbValid", 32'd0, Data'(i_wbValid));
            if (!i_stall)
            begin
                if (wbQueue.size() > 0)
                    wbQueue.delete(0);                          // Retired at this edge
                if (idValid && !i_flush && ex.writes)           // Flush kills the EX result
                begin
                    archRegs[ex.rd] = ex.value;
                    entry.addr      = ex.rd;
                    entry.data      = ex.value;
                    wbQueue.push_back(entry);
                end
                offered = runInstruction(i_inst, i_pc);
                idValid = i_instValid && offered.legal && !i_flush && !expRedirect;
                idInst  = i_inst;
                idPc    = i_pc;
            end
        end
        pending = wbQueue.size() + (idValid ? 1 : 0);
    end

endmodule

/* tb/tbIntegerCore.sv */
`timescale 1ns/100ps

module tbIntegerCore
    import CorePkg::*;
();

    localparam int          RunCycles  = 4000;           // Random cycles after reset
    localparam int          DrainLimit = 20;             // Cycles to empty the pipeline
    localparam logic [31:0] Seed       = 32'h34ea_e675;

    logic    clock;
    logic    arstN;
    logic    instValid;
    Data     inst;
    InstAddr pc;
    logic    stall;
    logic    flush;
    logic    wbValid;
    RegAddr  wbAddr;
    Data     wbData;
    logic    redirectValid;
    InstAddr redirectPc;
    int      errorCount;
    int      checkCount;
    int      pending;
    logic [31:0] lfsr;

    IntegerCore dut (
        .i_clock         (clock),
        .i_arstN         (arstN),
        .i_instValid     (instValid),
        .i_inst          (inst),
        .i_pc            (pc),
        .i_stall         (stall),
        .i_flush         (flush),
        .o_wbValid       (wbValid),
        .o_wbAddr        (wbAddr),
        .o_wbData        (wbData),
        .o_redirectValid (redirectValid),
        .o_redirectPc    (redirectPc));

    CoreChecker coreCheck (
        .i_clock         (clock),
        .i_arstN         (arstN),
        .i_instValid     (instValid),
        .i_inst          (inst),
        .i_pc            (pc),
        .i_stall         (stall),
        .i_flush         (flush),
        .i_wbValid       (wbValid),
        .i_wbAddr        (wbAddr),
        .i_wbData        (wbData),
        .i_redirectValid (redirectValid),
        .i_redirectPc    (redirectPc),
        .o_errorCount    (errorCount),
        .o_checkCount    (checkCount),
        .o_pending       (pending));

    initial
    begin
        clock = 1'b0;
        forever
            #4 clock = ~clock;                               // 8 ns period
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(int n);
        logic [31:0] v;

        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsrNext(lfsr);                           // One step per bit
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic RegAddr pickReg();
        logic [2:0] r;

        r = 3'(randBits(3));
        return (r > 3'd4) ? RegAddr'(r - 3'd4) : RegAddr'(r);  // x0 to x4 for dense hazards
    endfunction

    function automatic Data makeInst();
        logic [3:0] kind;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [6:0] upper;
        logic [4:0] lower;
        RegAddr     rd, rs1, rs2;
        Data        word;

        kind  = 4'(randBits(4));
        f3    = 3'(randBits(3));
        rd    = pickReg();
        rs1   = pickReg();
        rs2   = pickReg();
        f7    = (randBits(1) == 32'd1 && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
        upper = 7'(randBits(7));                             // Free immediate bits
        lower = 5'(randBits(5));
        case (kind)
            4'd0, 4'd1, 4'd2, 4'd3:
                word = {f7, rs2, rs1, f3, rd, 7'b0110011};                  // OP
            4'd4, 4'd5, 4'd6:
                word = {(f3 == 3'b001 || f3 == 3'b101) ? f7 : upper,
                        lower, rs1, f3, rd, 7'b0010011};                    // OP-IMM
            4'd7:
                word = {20'(randBits(20)), rd, 7'b0110111};                 // LUI
            4'd8:
                word = {20'(randBits(20)), rd, 7'b0010111};                 // AUIPC
            4'd9:
                word = {20'(randBits(20)), rd, 7'b1101111};                 // JAL
            4'd10:
                word = {12'(randBits(12)), rs1, 3'b000, rd, 7'b1100111};    // JALR
            4'd11, 4'd12, 4'd13:
                word = {upper, rs2, rs1, f3, lower, 7'b1100011};
            4'd14:
                word = {17'(randBits(17)), 3'b010, rd, 7'b0000011};         // Unsupported load
            default:
                word = {7'h01, rs2, rs1, f3, rd, 7'b0110011};               // Bad funct7
        endcase
        return word;
    endfunction

    initial
    begin
        int      cycle;
        int      waitCount;
        logic    accepted;
        logic    redirected;
        InstAddr target;
        InstAddr nextPc;

        lfsr      = Seed;
        arstN     = 1'b0;
        instValid = 1'b0;
        inst      = '0;
        pc        = '0;
        stall     = 1'b0;
        flush     = 1'b0;
        nextPc    = '0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        arstN = 1'b1;

        for (cycle = 0; cycle < RunCycles; cycle++)
        begin
            instValid  = (randBits(3) != 32'd0);             // Gaps now and then
            inst       = makeInst();
            pc         = nextPc;
            stall      = (randBits(3) == 32'd0);
            flush      = (randBits(6) == 32'd0);             // Rare
            accepted   = instValid && !stall;
            redirected = redirectValid && !stall;            // EX redirect is steady all cycle
            target     = redirectPc;
            @(posedge clock);
            @(negedge clock);
            if (redirected)
                nextPc = target;                             // Fetch follows the redirect
            else if (accepted)
                nextPc = nextPc + 32'd4;
        end

        instValid = 1'b0;
        stall     = 1'b0;
        flush     = 1'b0;
        waitCount = 0;
        while (pending != 0 && waitCount < DrainLimit)
        begin
            @(negedge clock);
            waitCount++;
        end
        @(negedge clock);                                    // One idle cycle checked too
        if (pending != 0)
            $display("Timeout: %0d instructions never retired after %0d cycles",
                     pending, DrainLimit);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (pending == 0 && errorCount == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* all.f */
+incdir+rtl
rtl/CorePkg.sv
rtl/WritebackIf.sv
rtl/InstDecoder.sv
rtl/RegisterFile.sv
rtl/PipelineStage.sv
rtl/ExecuteUnit.sv
rtl/IntegerCore.sv
tb/CoreChecker.sv
tb/tbIntegerCore.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := tbIntegerCore
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
